//--- Bender.yml
package:
  name: mac

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - mac_pkg.sv
      - array_mult8.sv
      - mac_datapath.sv
      - mac_accumulator.sv
      - mac_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - mac_asserts.sv
      - tb_mac.sv

//--- array_mult8.sv
// signed 8x8 array multiplier built from AND rows and ripple adder rows
`timescale 1ns/1ps

module array_mult8 (
	input  logic signed [7:0]  x,
	input  logic signed [7:0]  y,
	output logic signed [15:0] p
);

	// pp[i][j] is y[i] and x[j], weight 2**(i+j)
	logic [7:0] pp [8];

	// rows 1 to 7 as fed to the adder array
	logic [7:0] row [1:7];

	// row 7 before its sign term is inverted
	logic [7:0] top_row;

	// running partial sum into each adder row
	logic [7:0] add_a [1:7];

	// sum and carry chain of each adder row
	logic [7:0] add_s [1:7];
	logic [8:0] add_c [1:7];

	// product bits 1 to 7, one per adder row
	logic [7:1] low_bits;

	generate
		for (genvar i = 0; i < 8; i++) begin : g_pp
			for (genvar j = 0; j < 8; j++) begin : g_and
				assign pp[i][j] = y[i] & x[j];
			end
		end
	endgenerate

	// rows 1 to 6 carry their sign term inverted
	// each inversion owes a constant of -2**(i+7)
	generate
		for (genvar i = 1; i < 7; i++) begin : g_row
			assign row[i] = {~pp[i][7], pp[i][6:0]};
		end
	endgenerate

	// y[7] has negative weight, so this row is -x scaled by 2**7
	// complement here, the +1 enters as carry-in of the last adder row
	assign top_row = pp[7] ^ {8{y[7]}};
	assign row[7] = {~top_row[7], top_row[6:0]};

	// row 0 keeps its sign term plain at 2**7 and inverted at 2**8
	// which together equal the negative term plus a -2**8 constant
	assign add_a[1] = {~pp[0][7], pp[0][7:1]};

	generate
		for (genvar r = 2; r < 8; r++) begin : g_chain
			// previous carry out lands in the top bit of the next row
			assign add_a[r] = {add_c[r-1][8], add_s[r-1][7:1]};
		end
	endgenerate

	generate
		for (genvar r = 1; r < 8; r++) begin : g_add
			if (r == 7) begin : g_cin_last
				assign add_c[r][0] = y[7];
			end else begin : g_cin_zero
				assign add_c[r][0] = 1'b0;
			end

			for (genvar j = 0; j < 8; j++) begin : g_fa
				assign add_s[r][j] = add_a[r][j] ^ row[r][j] ^ add_c[r][j];
				assign add_c[r][j+1] = (add_a[r][j] & row[r][j])
					| (add_c[r][j] & (add_a[r][j] ^ row[r][j]));
			end

			// lowest sum bit is final, the rest shift down one place
			assign low_bits[r] = add_s[r][0];
		end
	endgenerate

	// the sign constants add up to -2**15
	// modulo 2**16 that is a single 1 in the top bit
	assign p = {~add_c[7][8], add_s[7][7:1], low_bits, pp[0][0]};

endmodule

//--- mac.f
+incdir+.
mac_pkg.sv
array_mult8.sv
mac_datapath.sv
mac_accumulator.sv
mac_top.sv
mac_asserts.sv
tb_mac.sv

//--- mac_accumulator.sv
// accumulator stage with clear-load, wrap-around sum and sticky overflow
`timescale 1ns/1ps

module mac_accumulator (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 prod_valid,
	input  mac_pkg::mac_prod_t   prod,
	output logic                 out_valid,
	output mac_pkg::mac_result_t out_res
);

	import mac_pkg::*;

	logic signed [ACC_W-1:0] acc_q;
	logic                    ovf_q;

	// product widened to the accumulator
	logic signed [ACC_W-1:0] prod_ext;

	// next sum and its overflow test
	logic signed [ACC_W-1:0] sum;
	logic                    add_ovf;

	assign prod_ext = {{(ACC_W - PROD_W){prod.product[PROD_W-1]}}, prod.product};

	// wraps modulo 2**ACC_W
	assign sum = acc_q + prod_ext;

	// same-sign addends giving a result of the other sign
	assign add_ovf = (acc_q[ACC_W-1] == prod_ext[ACC_W-1])
		&& (sum[ACC_W-1] != acc_q[ACC_W-1]);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= prod_valid;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			acc_q <= '0;
			ovf_q <= 1'b0;
		end else if (prod_valid) begin
			if (prod.clear) begin
				// new sum starts from this product
				acc_q <= prod_ext;
				ovf_q <= 1'b0;
			end else begin
				acc_q <= sum;
				ovf_q <= ovf_q | add_ovf;
			end
		end
	end

	assign out_res.acc      = acc_q;
	assign out_res.overflow = ovf_q;

endmodule

//--- mac_asserts.sv
// bound checks on reset, pipeline latency and sticky overflow of the MAC unit
`timescale 1ns/1ps
`include "mac_params.svh"

module mac_asserts (
	input logic clk,
	input logic rst_n,
	input logic in_valid,
	input logic out_valid,
	input logic overflow,
	input logic clear_item
);

	// number of failed assertions
	int fail_count = 0;

	// no result while held in reset
	a_reset_quiet: assert property (@(posedge clk) !rst_n |-> !out_valid)
		else begin
			fail_count++;
			$error("out_valid high during reset");
		end

	// every item gives a result a fixed number of edges later
	a_latency: assert property (@(posedge clk) disable iff (!rst_n)
		in_valid |-> ##(`MAC_LATENCY) out_valid)
		else begin
			fail_count++;
			$error("out_valid missing after an accepted item");
		end

	// and no result appears without an item behind it
	a_no_stray: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid |-> $past(in_valid, `MAC_LATENCY))
		else begin
			fail_count++;
			$error("out_valid without a matching item");
		end

	// overflow only drops when a clear item reaches the accumulator
	a_sticky_ovf: assert property (@(posedge clk) disable iff (!rst_n)
		$fell(overflow) |-> $past(clear_item))
		else begin
			fail_count++;
			$error("overflow fell without a clear item");
		end

endmodule

// accumulator input strobes are taken from the top level wiring
bind mac_top mac_asserts i_mac_asserts (
	.clk        (clk),
	.rst_n      (rst_n),
	.in_valid   (in_valid),
	.out_valid  (out_valid),
	.overflow   (out_res.overflow),
	.clear_item (prod_valid && prod.clear)
);

//--- mac_datapath.sv
// operand and product stages of the multiply-accumulate pipeline
`timescale 1ns/1ps

module mac_datapath (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               in_valid,
	input  mac_pkg::mac_op_t   in_op,
	output logic               prod_valid,
	output mac_pkg::mac_prod_t prod
);

	import mac_pkg::*;

	// operand stage
	logic    op_valid;
	mac_op_t op_q;

	// multiplier output, settles within the cycle after op_q loads
	logic signed [PROD_W-1:0] mult_p;

	// valid strobes move one stage per edge
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			op_valid   <= 1'b0;
			prod_valid <= 1'b0;
		end else begin
			op_valid   <= in_valid;
			prod_valid <= op_valid;
		end
	end

	// operands load only with a valid item
	always_ff @(posedge clk) begin
		if (in_valid) begin
			op_q <= in_op;
		end
	end

	array_mult8 u_mult (
		.x (op_q.x),
		.y (op_q.y),
		.p (mult_p)
	);

	// clear follows its own product to the accumulator
	always_ff @(posedge clk) begin
		if (op_valid) begin
			prod.product <= mult_p;
			prod.clear   <= op_q.clear;
		end
	end

endmodule

//--- mac_params.svh
// width and latency constants for the multiply-accumulate unit
`ifndef MAC_PARAMS_SVH
`define MAC_PARAMS_SVH

// accumulator width in bits
// must hold at least one full 16-bit product plus a sign bit
`define MAC_ACC_WIDTH 24

// rising edges from input sampling to a valid result
// operand register, product register, accumulator register
`define MAC_LATENCY 3

`endif

//--- mac_pkg.sv
// item types passed between the multiply-accumulate pipeline stages
`include "mac_params.svh"

package mac_pkg;

	// operand width is fixed by the array multiplier
	localparam int OP_W = 8;

	// full signed product of two operands
	localparam int PROD_W = 2 * OP_W;

	localparam int ACC_W = `MAC_ACC_WIDTH;

	// one input item
	// clear starts a new sum with this item's product
	typedef struct packed {
		logic signed [OP_W-1:0] x;
		logic signed [OP_W-1:0] y;
		logic                   clear;
	} mac_op_t;

	// product stage output
	// clear rides along unchanged
	typedef struct packed {
		logic signed [PROD_W-1:0] product;
		logic                     clear;
	} mac_prod_t;

	// accumulator state as seen at the outputs
	// overflow is sticky until the next clear item
	typedef struct packed {
		logic signed [ACC_W-1:0] acc;
		logic                    overflow;
	} mac_result_t;

endpackage

//--- mac_top.sv
// signed 8-bit multiply-accumulate unit with a three-stage pipeline
`timescale 1ns/1ps

module mac_top (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 in_valid,
	input  mac_pkg::mac_op_t     in_op,
	output logic                 out_valid,
	output mac_pkg::mac_result_t out_res
);

	import mac_pkg::*;

	// product stage to accumulator
	logic      prod_valid;
	mac_prod_t prod;

	mac_datapath u_datapath (
		.clk        (clk),
		.rst_n      (rst_n),
		.in_valid   (in_valid),
		.in_op      (in_op),
		.prod_valid (prod_valid),
		.prod       (prod)
	);

	mac_accumulator u_accumulator (
		.clk        (clk),
		.rst_n      (rst_n),
		.prod_valid (prod_valid),
		.prod       (prod),
		.out_valid  (out_valid),
		.out_res    (out_res)
	);

endmodule

//--- tb_mac.sv
// testbench for the signed multiply-accumulate unit, table driven with a reference model
`timescale 1ns/1ps
`include "mac_params.svh"

module tb_mac;

	import mac_pkg::*;

	// results may lag the last item by the pipeline depth plus slack
	localparam int DRAIN_LIMIT = `MAC_LATENCY + 8;
	localparam int NUM_TESTS = 6;

	// one table row: an item, how often to send it, idle cycles after it
	typedef struct {
		mac_op_t op;
		int      reps;
		int      gap;
		int      test;
	} stim_t;

	logic        clk;
	logic        rst_n;
	logic        in_valid;
	mac_op_t     in_op;
	logic        out_valid;
	mac_result_t out_res;

	stim_t       stim_q [$];
	mac_result_t exp_q [$];
	int          issue_q [$];
	mac_result_t model_state;
	string       test_names [NUM_TESTS];

	int cycle = 0;
	int error_count = 0;
	int check_count = 0;
	int result_count = 0;

	mac_top i_dut (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.in_op     (in_op),
		.out_valid (out_valid),
		.out_res   (out_res)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#4 clk = ~clk;
		end
	end

	always @(posedge clk) begin
		cycle <= cycle + 1;
	end

	// expected state after one item, from the clear, wrap and sticky rules
	function automatic mac_result_t model_step(input mac_result_t prev, input mac_op_t op);
		longint      prod_v;
		longint      acc_v;
		longint      sum_v;
		longint      acc_max;
		longint      acc_min;
		mac_result_t next;
		acc_max = (64'sd1 <<< (ACC_W - 1)) - 1;
		acc_min = -(64'sd1 <<< (ACC_W - 1));
		prod_v = longint'($signed(op.x)) * longint'($signed(op.y));
		acc_v = $signed(prev.acc);
		if (op.clear) begin
			next.acc = prod_v[ACC_W-1:0];
			next.overflow = 1'b0;
		end else begin
			sum_v = acc_v + prod_v;
			next.acc = sum_v[ACC_W-1:0];
			next.overflow = prev.overflow | (sum_v > acc_max) | (sum_v < acc_min);
		end
		return next;
	endfunction

	function automatic void add_entry(input int test, input int x, input int y,
		input bit clear, input int reps, input int gap);
		stim_t s;
		s.op.x = x[7:0];
		s.op.y = y[7:0];
		s.op.clear = clear;
		s.reps = reps;
		s.gap = gap;
		s.test = test;
		stim_q.push_back(s);
	endfunction

	function automatic void build_table();
		test_names[0] = "reset then unclear item";
		add_entry(0, 13, -9, 1'b0, 1, 2);
		add_entry(0, -4, 6, 1'b0, 1, 0);

		test_names[1] = "extreme products";
		add_entry(1, -128, -128, 1'b1, 1, 1);
		add_entry(1, -128, 127, 1'b1, 1, 0);
		add_entry(1, 127, 127, 1'b1, 1, 2);
		add_entry(1, 127, -128, 1'b1, 1, 0);
		add_entry(1, 0, -128, 1'b1, 1, 1);
		add_entry(1, -128, 0, 1'b1, 1, 0);
		add_entry(1, 0, 0, 1'b1, 1, 0);
		add_entry(1, -1, -1, 1'b1, 1, 0);
		add_entry(1, 1, -1, 1'b1, 1, 3);

		test_names[2] = "running sum across zero";
		add_entry(2, 3, 4, 1'b1, 1, 0);
		add_entry(2, -10, 10, 1'b0, 1, 0);
		add_entry(2, -7, 9, 1'b0, 1, 1);
		add_entry(2, 25, 5, 1'b0, 1, 0);
		add_entry(2, -128, 1, 1'b0, 2, 0);
		add_entry(2, 127, 2, 1'b0, 1, 2);

		test_names[3] = "clear inside a run";
		add_entry(3, 20, 20, 1'b1, 1, 0);
		add_entry(3, 30, 30, 1'b0, 1, 0);
		add_entry(3, -3, 7, 1'b1, 1, 0);
		add_entry(3, 2, 2, 1'b0, 3, 1);

		// 513 times 2**14 passes the 24-bit positive limit
		test_names[4] = "overflow wrap and clear";
		add_entry(4, 1, 1, 1'b1, 1, 0);
		add_entry(4, -128, -128, 1'b0, 513, 0);
		add_entry(4, 2, 3, 1'b1, 1, 2);
		add_entry(4, -128, 127, 1'b0, 520, 0);
		add_entry(4, 1, 1, 1'b1, 1, 1);

		test_names[5] = "streams and random operands";
		add_entry(5, 7, -3, 1'b0, 6, 0);
		for (int i = 1; i <= 12; i++) begin
			add_entry(5, i * 9, -i, 1'b0, 1, $urandom_range(0, 4));
		end
		for (int i = 0; i < 40; i++) begin
			add_entry(5, $urandom_range(0, 255), $urandom_range(0, 255),
				($urandom_range(0, 7) == 0), 1, $urandom_range(0, 2));
		end
	endfunction

	task automatic check_result(input mac_result_t got, input mac_result_t exp);
		check_count++;
		if (got !== exp) begin
			error_count++;
			$display("mismatch at %0t: acc %0d overflow %0b, expected acc %0d overflow %0b",
				$time, got.acc, got.overflow, exp.acc, exp.overflow);
		end
	endtask

	// in_cycle is the edge that sampled the item, counted as the first
	task automatic check_latency(input int in_cycle, input int out_cycle);
		int edges;
		edges = out_cycle - in_cycle + 1;
		check_count++;
		if (edges != `MAC_LATENCY) begin
			error_count++;
			$display("mismatch at %0t: result after %0d edges, expected %0d",
				$time, edges, `MAC_LATENCY);
		end
	endtask

	task automatic drive_item(input mac_op_t op);
		@(posedge clk);
		#1;
		in_valid = 1'b1;
		in_op = op;
		model_state = model_step(model_state, op);
		exp_q.push_back(model_state);
		issue_q.push_back(cycle + 1);
	endtask

	task automatic idle(input int n);
		repeat (n) begin
			@(posedge clk);
			#1;
			in_valid = 1'b0;
		end
	endtask

	task automatic wait_drain();
		int waited;
		waited = 0;
		@(posedge clk);
		#1;
		in_valid = 1'b0;
		while (exp_q.size() != 0 && waited < DRAIN_LIMIT) begin
			@(negedge clk);
			waited++;
		end
		if (exp_q.size() != 0) begin
			error_count++;
			$display("timeout: %0d results still missing after %0d cycles",
				exp_q.size(), waited);
			exp_q.delete();
			issue_q.delete();
		end
	endtask

	// outputs are read mid-cycle, away from the edges
	always @(negedge clk) begin
		if (rst_n && out_valid) begin
			if (exp_q.size() == 0) begin
				error_count++;
				$display("out_valid high at %0t with no item in flight", $time);
			end else begin
				result_count++;
				check_result(out_res, exp_q.pop_front());
				check_latency(issue_q.pop_front(), cycle);
			end
		end
	end

	initial begin
		int          err_mark;
		int          res_mark;
		mac_result_t reset_res;
		void'($urandom(29));
		rst_n = 1'b1;
		in_valid = 1'b0;
		in_op = '0;
		model_state = '0;
		reset_res = '0;
		err_mark = 0;
		res_mark = 0;
		build_table();

		#1;
		rst_n = 1'b0;
		repeat (16) @(posedge clk);
		#1;
		rst_n = 1'b1;

		@(negedge clk);
		if (out_valid !== 1'b0) begin
			error_count++;
			$display("mismatch at %0t: out_valid high right after reset", $time);
		end
		check_result(out_res, reset_res);

		for (int e = 0; e < stim_q.size(); e++) begin
			for (int r = 0; r < stim_q[e].reps; r++) begin
				drive_item(stim_q[e].op);
			end
			idle(stim_q[e].gap);
			if (e == stim_q.size() - 1 || stim_q[e + 1].test != stim_q[e].test) begin
				wait_drain();
				$display("test %0d (%s): %0d results, %0d errors, %s",
					stim_q[e].test, test_names[stim_q[e].test], result_count - res_mark,
					error_count - err_mark, (error_count == err_mark) ? "ok" : "failed");
				err_mark = error_count;
				res_mark = result_count;
			end
		end

		idle(4);
		error_count += i_dut.i_mac_asserts.fail_count;
		$display("%0d tests, %0d results, %0d checks, %0d errors",
			NUM_TESTS, result_count, check_count, error_count);
		if (error_count == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule
